/* hdl/dataslot_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared definitions for the dataslot command path
// widths with a meaning, size table constants, request kinds,
// issuer states and the command structs passed between blocks
////////////////////////////////////////////////////////////////////////////

package dataslot_pkg;

  //////////////////////////////////////////////////////////////////////////
  // constants

  // size table, two words per slot
  localparam int TABLE_DEPTH      = 1024;
  localparam int TABLE_INDEX_W    = $clog2(TABLE_DEPTH);
  // word within a slot's pair that carries the file size
  localparam int SIZE_WORD_OFFSET = 1;

  // one request level per kind
  localparam int NUM_REQ_KINDS    = 4;

  //////////////////////////////////////////////////////////////////////////
  // plain vector types

  typedef logic [15:0]              slot_id_t;
  typedef logic [TABLE_INDEX_W-1:0] table_index_t;
  typedef logic [31:0]              file_size_t;
  typedef logic [31:0]              byte_offset_t;

  //////////////////////////////////////////////////////////////////////////
  // enums

  // code doubles as the bit position in the request levels
  typedef enum logic [1:0] {
    READ     = 2'd0,
    WRITE    = 2'd1,
    GETFILE  = 2'd2,
    OPENFILE = 2'd3
  } req_kind_t;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    LOOKUP = 2'd1,
    OFFER  = 2'd2
  } issuer_state_t;

  //////////////////////////////////////////////////////////////////////////
  // command structs

  // 82 bits
  typedef struct packed {
    req_kind_t    kind;
    slot_id_t     slot_id;
    byte_offset_t offset;
    byte_offset_t length;
  } dataslot_cmd_t;

  // 114 bits, command plus the slot's recorded size
  typedef struct packed {
    dataslot_cmd_t cmd;
    file_size_t    file_size;
  } issued_cmd_t;

endpackage

/* hdl/request_edge_encoder.sv */
////////////////////////////////////////////////////////////////////////////
// request edge detector and priority encoder
// rising edges of the four request levels, fixed priority selection,
// one edge stage and a one-deep pending command with valid/ready
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module request_edge_encoder (
  input  logic                                     clk_sys_57_12,
  input  logic                                     arst_n,
  input  logic [dataslot_pkg::NUM_REQ_KINDS-1:0]   req_levels,
  input  dataslot_pkg::slot_id_t                   req_slot_id,
  input  dataslot_pkg::byte_offset_t               req_offset,
  input  dataslot_pkg::byte_offset_t               req_length,
  input  logic                                     pend_ready,
  output logic                                     pend_valid,
  output dataslot_pkg::dataslot_cmd_t              pend_cmd
);

  import dataslot_pkg::*;

  logic [NUM_REQ_KINDS-1:0] levels_q;
  logic [NUM_REQ_KINDS-1:0] rise;
  req_kind_t                rise_kind;
  dataslot_cmd_t            rise_cmd;
  logic                     stage_valid;
  dataslot_cmd_t            stage_cmd;
  logic                     pend_free;

  //////////////////////////////////////////////////////////////////////////
  // edge detection and priority

  // a level held high shows no edge after its first cycle
  assign rise = req_levels & ~levels_q;

  // read first, openfile last
  always_comb begin
    if (rise[READ]) begin
      rise_kind = READ;
    end else if (rise[WRITE]) begin
      rise_kind = WRITE;
    end else if (rise[GETFILE]) begin
      rise_kind = GETFILE;
    end else begin
      rise_kind = OPENFILE;
    end
  end

  assign rise_cmd = '{
    kind:    rise_kind,
    slot_id: req_slot_id,
    offset:  req_offset,
    length:  req_length
  };

  //////////////////////////////////////////////////////////////////////////
  // edge stage and pending register

  // slot is free when empty or emptied by a transfer this cycle
  assign pend_free = !pend_valid || pend_ready;

  always_ff @(posedge clk_sys_57_12 or negedge arst_n) begin
    if (!arst_n) begin
      levels_q    <= '0;
      stage_valid <= 1'b0;
      pend_valid  <= 1'b0;
    end else begin
      levels_q    <= req_levels;
      stage_valid <= |rise;
      // staged edge dropped when the pending command is still held
      if (stage_valid && pend_free) begin
        pend_valid <= 1'b1;
      end else if (pend_ready) begin
        pend_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_sys_57_12) begin
    if (|rise) begin
      stage_cmd <= rise_cmd;
    end
    if (stage_valid && pend_free) begin
      pend_cmd <= stage_cmd;
    end
  end

endmodule

/* hdl/slot_size_table.sv */
////////////////////////////////////////////////////////////////////////////
// slot file size table
// host update port on the update level's rising edge, core write port
// with priority over the host, registered read port for lookups
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module slot_size_table (
  input  logic                     clk_sys_57_12,
  input  logic                     arst_n,
  input  logic                     host_update,
  input  dataslot_pkg::slot_id_t   host_update_id,
  input  dataslot_pkg::file_size_t host_update_size,
  input  logic                     core_size_wr,
  input  dataslot_pkg::slot_id_t   core_size_id,
  input  dataslot_pkg::file_size_t core_size_data,
  input  dataslot_pkg::slot_id_t   lookup_id,
  output dataslot_pkg::file_size_t lookup_size
);

  import dataslot_pkg::*;

  file_size_t   size_mem [TABLE_DEPTH];

  logic         host_update_q;
  logic         host_rise;
  logic         wr_en;
  table_index_t wr_index;
  file_size_t   wr_data;
  table_index_t rd_index;

  // slot s owns words 2s and 2s+1, only the low slot bits reach the table
  function automatic table_index_t size_index(slot_id_t id);
    return {id[TABLE_INDEX_W-2:0], 1'b0} + table_index_t'(SIZE_WORD_OFFSET);
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // host update edge

  always_ff @(posedge clk_sys_57_12 or negedge arst_n) begin
    if (!arst_n) begin
      host_update_q <= 1'b0;
    end else begin
      host_update_q <= host_update;
    end
  end

  assign host_rise = host_update && !host_update_q;

  //////////////////////////////////////////////////////////////////////////
  // write arbitration

  // core write wins, a host edge in the same cycle is lost
  // whatever slot it addressed
  always_comb begin
    wr_en = core_size_wr || host_rise;
    if (core_size_wr) begin
      wr_index = size_index(core_size_id);
      wr_data  = core_size_data;
    end else begin
      wr_index = size_index(host_update_id);
      wr_data  = host_update_size;
    end
  end

  assign rd_index = size_index(lookup_id);

  //////////////////////////////////////////////////////////////////////////
  // storage

  // Read returns old data when it hits the word being written.
  always_ff @(posedge clk_sys_57_12) begin
    if (wr_en) begin
      size_mem[wr_index] <= wr_data;
    end
    lookup_size <= size_mem[rd_index];
  end

endmodule

/* hdl/target_cmd_issuer.sv */
////////////////////////////////////////////////////////////////////////////
// target command issuer
// IDLE/LOOKUP/OFFER FSM, takes a pending command, reads the slot size
// from the table and offers the merged command on valid/ready
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module target_cmd_issuer (
  input  logic                        clk_sys_57_12,
  input  logic                        arst_n,
  input  logic                        pend_valid,
  input  dataslot_pkg::dataslot_cmd_t pend_cmd,
  input  dataslot_pkg::file_size_t    lookup_size,
  input  logic                        out_ready,
  output logic                        pend_ready,
  output dataslot_pkg::slot_id_t      lookup_id,
  output logic                        out_valid,
  output dataslot_pkg::issued_cmd_t   out_cmd
);

  import dataslot_pkg::*;

  issuer_state_t state;
  issuer_state_t state_nxt;
  dataslot_cmd_t held_cmd;
  logic          accept;

  //////////////////////////////////////////////////////////////////////////
  // handshakes

  // only one command in the issuer, a second one waits upstream
  assign pend_ready = (state == IDLE);
  assign accept     = pend_ready && pend_valid;
  assign out_valid  = (state == OFFER);

  // id goes to the table in the accept cycle so the size
  // is back during LOOKUP
  assign lookup_id = (state == IDLE) ? pend_cmd.slot_id : held_cmd.slot_id;

  //////////////////////////////////////////////////////////////////////////
  // fsm

  always_comb begin
    state_nxt = state;
    unique case (state)
      IDLE: begin
        if (pend_valid) begin
          state_nxt = LOOKUP;
        end
      end
      LOOKUP: begin
        state_nxt = OFFER;
      end
      OFFER: begin
        if (out_ready) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_sys_57_12 or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // command and size

  // out_cmd only loads in LOOKUP, so it stays put through OFFER
  always_ff @(posedge clk_sys_57_12) begin
    if (accept) begin
      held_cmd <= pend_cmd;
    end
    if (state == LOOKUP) begin
      out_cmd.cmd       <= held_cmd;
      out_cmd.file_size <= lookup_size;
    end
  end

endmodule

/* hdl/dataslot_cmd_top.sv */
////////////////////////////////////////////////////////////////////////////
// dataslot command path top level
// request encoder and size table side by side, issuer merging both
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dataslot_cmd_top (
  input  logic                                   clk_sys_57_12,
  input  logic                                   arst_n,
  input  logic [dataslot_pkg::NUM_REQ_KINDS-1:0] req_levels,
  input  dataslot_pkg::slot_id_t                 req_slot_id,
  input  dataslot_pkg::byte_offset_t             req_offset,
  input  dataslot_pkg::byte_offset_t             req_length,
  input  logic                                   host_update,
  input  dataslot_pkg::slot_id_t                 host_update_id,
  input  dataslot_pkg::file_size_t               host_update_size,
  input  logic                                   core_size_wr,
  input  dataslot_pkg::slot_id_t                 core_size_id,
  input  dataslot_pkg::file_size_t               core_size_data,
  input  logic                                   out_ready,
  output logic                                   out_valid,
  output dataslot_pkg::issued_cmd_t              out_cmd
);

  import dataslot_pkg::*;

  // encoder to issuer
  logic          pend_valid;
  logic          pend_ready;
  dataslot_cmd_t pend_cmd;

  // issuer to table and back
  slot_id_t      lookup_id;
  file_size_t    lookup_size;

  request_edge_encoder i_encoder (
    .clk_sys_57_12 (clk_sys_57_12),
    .arst_n        (arst_n),
    .req_levels    (req_levels),
    .req_slot_id   (req_slot_id),
    .req_offset    (req_offset),
    .req_length    (req_length),
    .pend_ready    (pend_ready),
    .pend_valid    (pend_valid),
    .pend_cmd      (pend_cmd)
  );

  slot_size_table i_table (
    .clk_sys_57_12    (clk_sys_57_12),
    .arst_n           (arst_n),
    .host_update      (host_update),
    .host_update_id   (host_update_id),
    .host_update_size (host_update_size),
    .core_size_wr     (core_size_wr),
    .core_size_id     (core_size_id),
    .core_size_data   (core_size_data),
    .lookup_id        (lookup_id),
    .lookup_size      (lookup_size)
  );

  target_cmd_issuer i_issuer (
    .clk_sys_57_12 (clk_sys_57_12),
    .arst_n        (arst_n),
    .pend_valid    (pend_valid),
    .pend_cmd      (pend_cmd),
    .lookup_size   (lookup_size),
    .out_ready     (out_ready),
    .pend_ready    (pend_ready),
    .lookup_id     (lookup_id),
    .out_valid     (out_valid),
    .out_cmd       (out_cmd)
  );

endmodule

/* bench/dataslot_cmd_assert.sv */
////////////////////////////////////////////////////////////////////////////
// concurrent assertions on the output handshake of the top level,
// bound into dataslot_cmd_top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dataslot_cmd_assert (
  input logic                      clk_sys_57_12,
  input logic                      arst_n,
  input logic                      out_valid,
  input logic                      out_ready,
  input dataslot_pkg::issued_cmd_t out_cmd
);

  // failed checks so far, watched by the testbench
  int violations = 0;

  // payload frozen while the consumer stalls
  stable_payload: assert property (@(posedge clk_sys_57_12) disable iff (!arst_n)
    out_valid && !out_ready |=> $stable(out_cmd)
  ) else begin
    violations++;
    $error("out_cmd changed while waiting for out_ready");
  end

  quiet_in_reset: assert property (@(posedge clk_sys_57_12)
    !arst_n |-> !out_valid
  ) else begin
    violations++;
    $error("out_valid high during reset");
  end

  // valid only drops through a transfer
  no_drop: assert property (@(posedge clk_sys_57_12) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid
  ) else begin
    violations++;
    $error("out_valid fell without a transfer");
  end

endmodule

bind dataslot_cmd_top dataslot_cmd_assert i_assert (
  .clk_sys_57_12 (clk_sys_57_12),
  .arst_n        (arst_n),
  .out_valid     (out_valid),
  .out_ready     (out_ready),
  .out_cmd       (out_cmd)
);

/* bench/dataslot_cmd_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the dataslot command path
// clock and reset, directed and random stimulus, size table model,
// reference function, compare process and timeout
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dataslot_cmd_tb;

  import dataslot_pkg::*;

  localparam int RANDOM_REQUESTS = 200;
  localparam int NUM_REQUESTS    = 10 + RANDOM_REQUESTS;
  localparam int TIMEOUT_CYCLES  = 40 * NUM_REQUESTS + 2000;
  localparam int NUM_SLOTS       = 12;

  logic                     clk_sys_57_12 = 1'b0;
  logic                     arst_n;
  logic [NUM_REQ_KINDS-1:0] req_levels;
  slot_id_t                 req_slot_id;
  byte_offset_t             req_offset;
  byte_offset_t             req_length;
  logic                     host_update;
  slot_id_t                 host_update_id;
  file_size_t               host_update_size;
  logic                     core_size_wr;
  slot_id_t                 core_size_id;
  file_size_t               core_size_data;
  logic                     out_ready = 1'b1;
  logic                     out_valid;
  issued_cmd_t              out_cmd;

  logic        ready_hold   = 1'b1;
  logic        ready_random = 1'b0;
  int          cycle_count  = 0;
  string       test_name    = "reset";
  issued_cmd_t exp_q [$];
  file_size_t  size_model [slot_id_t];
  slot_id_t    slots [NUM_SLOTS];

  dataslot_cmd_top i_dut (.*);

  always #5 clk_sys_57_12 = ~clk_sys_57_12;

  always @(posedge clk_sys_57_12) begin
    out_ready <= ready_random ? ($urandom_range(0, 1) != 0) : ready_hold;
  end

  ////////////////////////////////////////////////////////////////////////////
  // model and reference

  // only the low nine bits of a slot id select a table entry
  function automatic slot_id_t table_key(slot_id_t id);
    return id & 16'h01ff;
  endfunction

  // highest priority kind wins, read first
  function automatic issued_cmd_t expect_issued(logic [NUM_REQ_KINDS-1:0] levels,
                                                slot_id_t id, byte_offset_t off,
                                                byte_offset_t len);
    issued_cmd_t expected;
    expected.cmd.kind    = levels[0] ? READ : levels[1] ? WRITE : levels[2] ? GETFILE : OPENFILE;
    expected.cmd.slot_id = id;
    expected.cmd.offset  = off;
    expected.cmd.length  = len;
    expected.file_size   = size_model.exists(table_key(id)) ? size_model[table_key(id)] : '0;
    return expected;
  endfunction

  task automatic check_issued(string name, issued_cmd_t expected, issued_cmd_t actual);
    if (actual !== expected) begin
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "issued command mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks

  // core write beats a host edge in the same cycle
  task automatic table_write(logic host, logic core, slot_id_t hid, file_size_t hsize,
                             slot_id_t cid, file_size_t csize);
    host_update      <= host;
    host_update_id   <= hid;
    host_update_size <= hsize;
    core_size_wr     <= core;
    core_size_id     <= cid;
    core_size_data   <= csize;
    @(posedge clk_sys_57_12);
    host_update  <= 1'b0;
    core_size_wr <= 1'b0;
    @(posedge clk_sys_57_12);
    if (core) begin
      size_model[table_key(cid)] = csize;
    end else if (host) begin
      size_model[table_key(hid)] = hsize;
    end
  endtask

  task automatic start_request(logic [NUM_REQ_KINDS-1:0] levels, slot_id_t id,
                               byte_offset_t off, byte_offset_t len);
    req_levels  <= levels;
    req_slot_id <= id;
    req_offset  <= off;
    req_length  <= len;
    exp_q.push_back(expect_issued(levels, id, off, len));
  endtask

  // levels stay up for hold cycles after the issuer took the command
  task automatic end_request(int hold);
    do begin
      @(posedge clk_sys_57_12);
    end while (!(i_dut.pend_valid && i_dut.pend_ready));
    repeat (hold) @(posedge clk_sys_57_12);
    req_levels <= '0;
    @(posedge clk_sys_57_12);
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk_sys_57_12);
    end
  endtask

  task automatic random_request();
    slot_id_t id;
    id = slots[$urandom_range(0, NUM_SLOTS - 1)];
    start_request(4'($urandom_range(1, 15)), id, $urandom(), $urandom());
    end_request($urandom_range(0, 3));
  endtask

  // 0 host only, 1 core only, 2 both in one cycle
  task automatic random_update();
    int mode;
    mode = $urandom_range(0, 2);
    table_write(mode != 1, mode != 0, slots[$urandom_range(0, NUM_SLOTS - 1)], $urandom(),
                slots[$urandom_range(0, NUM_SLOTS - 1)], $urandom());
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare and timeout

  always @(posedge clk_sys_57_12) begin : compare_proc
    issued_cmd_t expected;
    if (arst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("command came out although no request was pending");
        $display("Finished with errors");
        $fatal(1, "unexpected command");
      end else begin
        expected = exp_q.pop_front();
        check_issued(test_name, expected, out_cmd);
      end
    end
  end

  always @(posedge clk_sys_57_12) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end else if (i_dut.i_assert.violations != 0) begin
      $display("an assertion on the output handshake failed");
      $display("Finished with errors");
      $fatal(1, "assertion failure");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    void'($urandom(84273));
    arst_n           = 1'b1;
    req_levels       = '0;
    req_slot_id      = '0;
    req_offset       = '0;
    req_length       = '0;
    host_update      = 1'b0;
    host_update_id   = '0;
    host_update_size = '0;
    core_size_wr     = 1'b0;
    core_size_id     = '0;
    core_size_data   = '0;
    #1;
    arst_n = 1'b0;
    repeat (8) @(posedge clk_sys_57_12);
    arst_n <= 1'b1;
    @(posedge clk_sys_57_12);

    test_name = "host_update_read";
    table_write(1'b1, 1'b0, 16'h0005, 32'h0000_1234, '0, '0);
    start_request(4'b0001, 16'h0005, 32'h0000_0100, 32'h0000_0200);
    end_request(0);
    wait_drained();

    // several kinds together, levels held well past the accept
    test_name = "priority_edges";
    for (int i = 0; i < NUM_REQ_KINDS; i++) begin
      start_request(4'b1111 << i, 16'h0005, i, 32'h0000_0040);
      end_request(6);
      wait_drained();
      repeat (6) @(posedge clk_sys_57_12);
    end

    test_name = "core_write_wins";
    table_write(1'b1, 1'b0, 16'h0021, 32'h0000_1111, '0, '0);
    table_write(1'b1, 1'b0, 16'h0022, 32'h0000_2222, '0, '0);
    table_write(1'b1, 1'b1, 16'h0021, 32'h0000_3333, 16'h0021, 32'h0000_4444);
    start_request(4'b0001, 16'h0021, 32'h0000_0000, 32'h0000_0010);
    end_request(0);
    wait_drained();
    // host edge for another slot is dropped too
    table_write(1'b1, 1'b1, 16'h0022, 32'h0000_5555, 16'h0021, 32'h0000_6666);
    start_request(4'b0010, 16'h0022, 32'h0000_0004, 32'h0000_0020);
    end_request(0);
    start_request(4'b0100, 16'h0021, 32'h0000_0008, 32'h0000_0030);
    end_request(0);
    wait_drained();

    test_name = "back_pressure";
    ready_hold <= 1'b0;
    @(posedge clk_sys_57_12);
    start_request(4'b0001, 16'h0005, 32'h0000_0008, 32'h0000_0080);
    end_request(0);
    start_request(4'b1000, 16'h0022, 32'h0000_000c, 32'h0000_00c0);
    do begin
      @(posedge clk_sys_57_12);
    end while (!i_dut.pend_valid);
    req_levels <= '0;
    repeat (8) @(posedge clk_sys_57_12);
    if (!(out_valid && i_dut.pend_valid && exp_q.size() == 2)) begin
      $display("second command did not wait in the encoder behind the stalled output");
      $display("Finished with errors");
      $fatal(1, "back-pressure");
    end
    ready_hold <= 1'b1;
    wait_drained();

    test_name = "random_run";
    for (int i = 0; i < NUM_SLOTS; i++) begin
      slots[i] = slot_id_t'($urandom());
      table_write(1'b1, 1'b0, slots[i], $urandom(), '0, '0);
    end
    ready_random <= 1'b1;
    for (int n = 0; n < RANDOM_REQUESTS; n++) begin
      if ($urandom_range(0, 3) == 0) begin
        wait_drained();
        random_update();
      end
      random_request();
    end
    wait_drained();
    ready_random <= 1'b0;
    repeat (8) @(posedge clk_sys_57_12);

    if (exp_q.size() == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("expected commands never came out");
      $display("Finished with errors");
      $fatal(1, "missing commands");
    end
  end

endmodule

/* dataslot_cmd_top.f */
hdl/dataslot_pkg.sv
hdl/request_edge_encoder.sv
hdl/slot_size_table.sv
hdl/target_cmd_issuer.sv
hdl/dataslot_cmd_top.sv
bench/dataslot_cmd_assert.sv
bench/dataslot_cmd_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and decide from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module dataslot_cmd_tb \
  -f dataslot_cmd_top.f -o dataslot_cmd_sim \
  && ./obj_dir/dataslot_cmd_sim > sim.log 2>&1
grep -qx "Finished with no errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
